/* hw/dcache_pkg.sv */
// --------------------
// Cache geometry, opcodes and bus types for the data cache stage
// Only the low cacheable_bits of an address are cached, so higher bits alias
// --------------------
package dcache_pkg;

   // -------------------- Geometry
   localparam int word_index_bits = 2;
   localparam int line_index_bits = 4;
   localparam int way_bits        = 2;
   localparam int cacheable_bits  = 16;
   localparam int tag_bits        = cacheable_bits - line_index_bits - word_index_bits - 2;
   // One slot stays empty so full and empty differ
   localparam int sb_depth_bits   = 2;

   localparam int num_ways    = 1 << way_bits;
   localparam int num_lines   = 1 << line_index_bits;
   localparam int sb_entries  = 1 << sb_depth_bits;
   localparam int data_words  = 1 << (way_bits + line_index_bits + word_index_bits);

   typedef logic [tag_bits-1:0]        tag_t;
   typedef logic [way_bits-1:0]        way_t;
   typedef logic [line_index_bits-1:0] index_t;
   typedef logic [word_index_bits-1:0] word_t;

   typedef enum logic [3:0] {
      op_none, op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb, op_sh, op_sw
   } mem_op_e;

   // -------------------- Address fields
   // Cached part of a byte address, high bit first
   typedef struct packed {
      tag_t       tag;
      index_t     index;
      word_t      word;
      logic [1:0] byte_sel;
   } cache_addr_t;

   // Word address inside the data RAM
   typedef struct packed {
      way_t   way;
      index_t index;
      word_t  word;
   } data_addr_t;

   // -------------------- Stage and bus records
   typedef struct packed {
      logic        valid;
      mem_op_e     op;
      logic [31:0] addr;
      logic [31:0] store_data;
      logic [31:0] alu_res;
      logic [5:0]  wbr;
      logic [31:0] pc;
   } stage_req_t;

   typedef struct packed {
      logic        valid;
      logic [5:0]  wbr;
      logic [31:0] res;
   } stage_res_t;

   typedef struct packed {
      logic        read;
      logic        write;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  be;
   } mem_req_t;

   typedef struct packed {
      logic        hold;
      logic [31:0] rdata;
   } mem_res_t;

   function automatic logic is_load(mem_op_e op);
      return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
   endfunction

   function automatic logic is_store(mem_op_e op);
      return op inside {op_sb, op_sh, op_sw};
   endfunction

endpackage

/* hw/tag_lookup.sv */
// --------------------
// Tag and valid store for all ways, read one cycle ahead of the compare
// --------------------
module tag_lookup
   import dcache_pkg::*;
(
   input  logic   clock,
   input  logic   rst,
   input  index_t rd_index,
   input  tag_t   chk,
   output logic   hit,
   output way_t   hit_way,
   input  logic   wr_en,
   input  way_t   wr_way,
   input  index_t wr_index,
   input  tag_t   wr_tag
);

   tag_t                 tags [num_ways][num_lines];
   logic [num_lines-1:0] valid [num_ways];
   tag_t                 rd_tag [num_ways];
   logic [num_ways-1:0]  rd_valid;
   logic [num_ways-1:0]  match;

   // Tag RAMs have no reset
   always_ff @(posedge clock) begin
      for (int w = 0; w < num_ways; w++) begin
         rd_tag[w] <= tags[w][rd_index];
         if (wr_en && wr_way == way_t'(w))
            tags[w][wr_index] <= wr_tag;
      end
   end

   // Valid bits
   always_ff @(posedge clock) begin
      if (rst) begin
         for (int w = 0; w < num_ways; w++)
            valid[w] <= '0;
         rd_valid <= '0;
      end else begin
         for (int w = 0; w < num_ways; w++)
            rd_valid[w] <= valid[w][rd_index];
         if (wr_en)
            valid[wr_way][wr_index] <= 1'b1;
      end
   end

   // At most one way matches, lowest wins otherwise
   always_comb begin
      hit_way = '0;
      for (int w = num_ways - 1; w >= 0; w--) begin
         match[w] = rd_valid[w] && rd_tag[w] == chk;
         if (match[w])
            hit_way = way_t'(w);
      end
   end

   assign hit = |match;

endmodule

/* hw/data_array.sv */
// --------------------
// Cache data RAM, port A byte-write plus read, port B fill write only
// --------------------
module data_array
   import dcache_pkg::*;
(
   input  logic        clock,
   input  data_addr_t  a_addr,
   input  logic [3:0]  a_be,
   input  logic [31:0] a_wdata,
   input  logic        a_we,
   output logic [31:0] a_rdata,
   input  data_addr_t  b_addr,
   input  logic [31:0] b_wdata,
   input  logic        b_we
);

   // Lane 3 is bits 31:24, the lowest byte address
   logic [3:0][7:0] mem [data_words];

   always_ff @(posedge clock) begin
      // Read returns the old word on a same-address write
      a_rdata <= mem[a_addr];
      if (a_we) begin
         for (int i = 0; i < 4; i++)
            if (a_be[i])
               mem[a_addr][i] <= a_wdata[8*i +: 8];
      end
      // Fill never targets the line port A is using
      if (b_we)
         mem[b_addr] <= b_wdata;
   end

endmodule

/* hw/lane_format.sv */
// --------------------
// Big-endian lane steering, no alignment check on halves or words
// --------------------
module lane_format
   import dcache_pkg::*;
(
   input  mem_op_e     op,
   input  logic [1:0]  st_addr_low,
   input  logic [31:0] st_data,
   output logic [31:0] st_wdata,
   output logic [3:0]  st_be,
   input  mem_op_e     ld_op,
   input  logic [1:0]  ld_addr_low,
   input  logic [31:0] ld_word,
   output logic [31:0] ld_res
);

   logic [15:0] ld_half;
   logic [7:0]  ld_byte;

   // -------------------- Store side
   // Replicate so every enabled lane sees the right bits
   always_comb begin
      case (op)
         op_sb: begin
            st_wdata = {4{st_data[7:0]}};
            st_be    = 4'b1000 >> st_addr_low;
         end
         op_sh: begin
            st_wdata = {2{st_data[15:0]}};
            st_be    = st_addr_low[1] ? 4'b0011 : 4'b1100;
         end
         op_sw: begin
            st_wdata = st_data;
            st_be    = 4'b1111;
         end
         default: begin
            st_wdata = st_data;
            st_be    = 4'b0000;
         end
      endcase
   end

   // -------------------- Load side
   // Address 0 is the high half and high byte
   assign ld_half = ld_addr_low[1] ? ld_word[15:0] : ld_word[31:16];
   assign ld_byte = ld_addr_low[0] ? ld_half[7:0] : ld_half[15:8];

   always_comb begin
      case (ld_op)
         op_lb:   ld_res = {{24{ld_byte[7]}}, ld_byte};
         op_lbu:  ld_res = {24'b0, ld_byte};
         op_lh:   ld_res = {{16{ld_half[15]}}, ld_half};
         op_lhu:  ld_res = {16'b0, ld_half};
         default: ld_res = ld_word;
      endcase
   end

endmodule

/* hw/store_buffer.sv */
// --------------------
// Write-through store queue, holds sb_entries - 1 stores
// A push while full is dropped and the caller restarts the store
// --------------------
module store_buffer
   import dcache_pkg::*;
(
   input  logic        clock,
   input  logic        rst,
   input  logic        push,
   input  logic [31:0] push_addr,
   input  logic [31:0] push_data,
   input  logic [3:0]  push_be,
   output logic        full,
   output mem_req_t    bus_req,
   input  logic        accepted
);

   mem_req_t                 entry [sb_entries];
   logic [sb_depth_bits-1:0] wp, rp, wp_next, rp_next;
   logic                     empty;

   assign wp_next = wp + sb_depth_bits'(1);
   assign rp_next = rp + sb_depth_bits'(1);
   assign empty   = wp == rp;
   assign full    = wp_next == rp;

   // Pointers
   always_ff @(posedge clock) begin
      if (rst) begin
         wp <= '0;
         rp <= '0;
      end else begin
         if (push && !full)
            wp <= wp_next;
         if (accepted && !empty)
            rp <= rp_next;
      end
   end

   // Entry storage
   always_ff @(posedge clock) begin
      if (push && !full) begin
         entry[wp].read  <= 1'b0;
         entry[wp].write <= 1'b1;
         entry[wp].addr  <= push_addr;
         entry[wp].wdata <= push_data;
         entry[wp].be    <= push_be;
      end
   end

   // Oldest entry is offered until the arbiter takes it
   always_comb begin
      bus_req       = entry[rp];
      bus_req.read  = 1'b0;
      bus_req.write = !empty;
   end

endmodule

/* hw/line_fill.sv */
// --------------------
// Line fetch on load miss, one line in flight, round-robin victim
// --------------------
module line_fill
   import dcache_pkg::*;
(
   input  logic        clock,
   input  logic        rst,
   input  logic        miss,
   input  index_t      miss_index,
   input  tag_t        miss_tag,
   output mem_req_t    bus_req,
   input  logic        accepted,
   input  logic [31:0] fill_data,
   input  logic        fill_data_valid,
   output logic [31:0] fill_wdata,
   output data_addr_t  fill_addr,
   output logic        fill_we,
   output logic        tag_we,
   output way_t        fill_way,
   output logic        busy
);

   // Issue sends the reads, drain waits for the last words
   typedef enum logic [1:0] {fill_idle, fill_issue, fill_drain} fill_state_e;

   fill_state_e state;
   way_t        victim;
   index_t      index_q;
   tag_t        tag_q;
   word_t       issue_wi, recv_wi;

   always_ff @(posedge clock) begin
      if (rst) begin
         state    <= fill_idle;
         victim   <= '0;
         issue_wi <= '0;
         recv_wi  <= '0;
      end else begin
         case (state)
            fill_idle:
               if (miss) begin
                  state    <= fill_issue;
                  victim   <= victim + 1'b1;
                  issue_wi <= '0;
                  recv_wi  <= '0;
               end
            fill_issue:
               if (accepted) begin
                  issue_wi <= issue_wi + 1'b1;
                  if (&issue_wi)
                     state <= fill_drain;
               end
            default: ;
         endcase
         // Words return in issue order
         if (fill_we) begin
            recv_wi <= recv_wi + 1'b1;
            if (&recv_wi)
               state <= fill_idle;
         end
      end
      if (state == fill_idle && miss) begin
         index_q <= miss_index;
         tag_q   <= miss_tag;
      end
   end

   // Address stays valid after the last read so the tag can be taken from it
   always_comb begin
      bus_req       = '0;
      bus_req.read  = state == fill_issue;
      bus_req.addr  = {{(32 - cacheable_bits){1'b0}}, tag_q, index_q, issue_wi, 2'b00};
      bus_req.be    = 4'hf;
   end

   assign busy       = state != fill_idle;
   assign fill_we    = busy & fill_data_valid;
   assign tag_we     = fill_we & (&recv_wi);
   assign fill_wdata = fill_data;
   assign fill_addr  = {victim, index_q, recv_wi};
   assign fill_way   = victim;

endmodule

/* hw/mem_arbiter.sv */
// --------------------
// Main memory bus mux, stores first, registered request
// --------------------
module mem_arbiter
   import dcache_pkg::*;
(
   input  logic        clock,
   input  logic        rst,
   input  mem_req_t    sb_req,
   input  mem_req_t    fill_req,
   output mem_req_t    mem_req,
   input  mem_res_t    mem_res,
   output logic        sb_accepted,
   output logic        fill_accepted,
   output logic [31:0] fill_data,
   output logic        fill_data_valid
);

   logic     sb_sel;
   mem_req_t sel;
   logic     rd_taken;

   assign sb_sel = sb_req.write;
   assign sel    = sb_sel ? sb_req : fill_req;

   // A source advances once its request is loaded into the bus register
   assign sb_accepted   = sb_sel & ~mem_res.hold;
   assign fill_accepted = ~sb_sel & fill_req.read & ~mem_res.hold;

   always_ff @(posedge clock) begin
      if (rst) begin
         mem_req.read  <= 1'b0;
         mem_req.write <= 1'b0;
         rd_taken      <= 1'b0;
      end else begin
         // Read data shows up the cycle after the read is taken
         rd_taken <= mem_req.read & ~mem_res.hold;
         if (!mem_res.hold)
            mem_req <= sel;
      end
   end

   assign fill_data       = mem_res.rdata;
   assign fill_data_valid = rd_taken;

endmodule

/* hw/dcache_stage.sv */
// --------------------
// Three-cycle memory stage, write-through and no-write-allocate
// Producer must stop while restart is high and then resend restart_pc
// --------------------
module dcache_stage
   import dcache_pkg::*;
(
   input  logic       clock,
   input  logic       rst,
   input  stage_req_t req,
   output stage_res_t res,
   output logic       restart,
   output logic [31:0] restart_pc,
   output mem_req_t   mem_req,
   input  mem_res_t   mem_res
);

   // Request as it leaves the hit check
   typedef struct packed {
      logic        valid;
      logic        miss;
      logic        full;
      mem_op_e     op;
      logic [1:0]  addr_low;
      logic [5:0]  wbr;
      logic [31:0] alu_res;
      logic [31:0] pc;
   } m_stage_t;

   stage_req_t  x_req;
   cache_addr_t req_fld, x_fld, fill_fld;
   m_stage_t    m_next, m_q;

   logic        x_hit, x_kill, x_live, x_load, x_store, x_miss;
   way_t        x_hit_way;
   logic [31:0] st_wdata, a_rdata, ld_res;
   logic [3:0]  st_be;
   logic        sb_full, m_cause;

   mem_req_t    sb_req, fill_req;
   logic        sb_accepted, fill_accepted;
   logic [31:0] fill_data, fill_wdata;
   logic        fill_data_valid, fill_we, tag_we, fill_busy;
   data_addr_t  fill_addr;
   way_t        fill_way;

   assign req_fld  = req.addr[cacheable_bits-1:0];
   assign x_fld    = x_req.addr[cacheable_bits-1:0];
   // Fill address register still carries the tag during the last word
   assign fill_fld = fill_req.addr[cacheable_bits-1:0];

   // -------------------- Tag stage
   always_ff @(posedge clock) begin
      if (rst)
         x_req.valid <= 1'b0;
      else
         x_req <= req;
   end

   tag_lookup u_tags (
      .clock, .rst,
      .rd_index (req_fld.index),
      .chk      (x_fld.tag),
      .hit      (x_hit),
      .hit_way  (x_hit_way),
      .wr_en    (tag_we),
      .wr_way   (fill_way),
      .wr_index (fill_addr.index),
      .wr_tag   (fill_fld.tag)
   );

   // -------------------- Hit check and data access
   // Anything behind a restart is dropped and will be resent
   assign m_cause = m_q.valid & (m_q.miss | m_q.full);
   assign x_kill  = restart | m_cause;
   assign x_live  = x_req.valid & ~x_kill;
   assign x_load  = x_live & is_load(x_req.op);
   assign x_store = x_live & is_store(x_req.op);
   assign x_miss  = x_load & ~x_hit;

   lane_format u_lanes (
      .op (x_req.op), .st_addr_low (x_req.addr[1:0]), .st_data (x_req.store_data),
      .st_wdata (st_wdata), .st_be (st_be),
      .ld_op (m_q.op), .ld_addr_low (m_q.addr_low), .ld_word (a_rdata), .ld_res (ld_res)
   );

   // Store hits update the line only when the buffer takes them too
   data_array u_data (
      .clock,
      .a_addr  ({x_hit_way, x_fld.index, x_fld.word}),
      .a_be    (st_be),
      .a_wdata (st_wdata),
      .a_we    (x_store & x_hit & ~sb_full),
      .a_rdata (a_rdata),
      .b_addr  (fill_addr),
      .b_wdata (fill_wdata),
      .b_we    (fill_we)
   );

   store_buffer u_sb (
      .clock, .rst,
      .push      (x_store),
      .push_addr ({x_req.addr[31:2], 2'b00}),
      .push_data (st_wdata),
      .push_be   (st_be),
      .full      (sb_full),
      .bus_req   (sb_req),
      .accepted  (sb_accepted)
   );

   line_fill u_fill (
      .clock, .rst,
      .miss (x_miss), .miss_index (x_fld.index), .miss_tag (x_fld.tag),
      .bus_req (fill_req), .accepted (fill_accepted),
      .fill_data, .fill_data_valid, .fill_wdata,
      .fill_addr, .fill_we, .tag_we, .fill_way, .busy (fill_busy)
   );

   mem_arbiter u_arb (
      .clock, .rst,
      .sb_req, .fill_req, .mem_req, .mem_res,
      .sb_accepted, .fill_accepted, .fill_data, .fill_data_valid
   );

   always_comb begin
      m_next.valid    = x_live;
      m_next.miss     = x_miss;
      m_next.full     = x_store & sb_full;
      m_next.op       = x_req.op;
      m_next.addr_low = x_req.addr[1:0];
      m_next.wbr      = x_req.wbr;
      m_next.alu_res  = x_req.alu_res;
      m_next.pc       = x_req.pc;
   end

   always_ff @(posedge clock) begin
      if (rst)
         m_q.valid <= 1'b0;
      else
         m_q <= m_next;
   end

   // -------------------- Result and restart
   // Miss restart stays up until the fill engine goes idle, a full buffer
   // restart lasts one cycle
   always_ff @(posedge clock) begin
      if (rst) begin
         res.valid <= 1'b0;
         restart   <= 1'b0;
      end else begin
         res.valid <= m_q.valid & ~m_q.miss & ~m_q.full;
         restart   <= m_cause | (restart & fill_busy);
      end
      res.wbr <= m_q.wbr;
      res.res <= is_load(m_q.op) ? ld_res : m_q.alu_res;
      if (m_cause)
         restart_pc <= m_q.pc;
   end

endmodule

/* sim/tb_memory.sv */
// --------------------
// Main memory model for the low 64 KiB, random hold, plus a byte shadow
// --------------------
module tb_memory
   import dcache_pkg::*;
(
   input  logic     clock,
   input  logic     heavy,
   input  mem_req_t mem_req,
   output mem_res_t mem_res
);

   localparam int mem_words = 1 << (cacheable_bits - 2);

   logic [31:0] mem [mem_words];
   logic [7:0]  shadow [1 << cacheable_bits];
   logic [31:0] rd_word;
   logic [31:0] rnd;
   mem_req_t    wr_log [$];

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // Every word address bit feeds the pattern
   function automatic logic [31:0] fill_word(input int wa);
      return (32'(wa) * 32'h9e37_79b1) ^ 32'h8040_c020;
   endfunction

   initial begin
      rnd     = 32'h2b4d24c5;
      mem_res = '0;
      rd_word = '0;
      for (int i = 0; i < mem_words; i++) begin
         mem[i] = fill_word(i);
         // Byte 0 of a word sits in bits 31:24
         for (int b = 0; b < 4; b++)
            shadow[4*i + b] = mem[i][31 - 8*b -: 8];
      end
   end

   // -------------------- Bus side
   // A request counts only on an edge with hold low
   always @(posedge clock) begin
      if (!mem_res.hold) begin
         if (mem_req.write) begin
            for (int i = 0; i < 4; i++)
               if (mem_req.be[i])
                  mem[mem_req.addr[cacheable_bits-1:2]][8*i +: 8] = mem_req.wdata[8*i +: 8];
            wr_log.push_back(mem_req);
         end
         if (mem_req.read)
            rd_word <= mem[mem_req.addr[cacheable_bits-1:2]];
      end
   end

   // Response changes on the falling edge
   always @(negedge clock) begin
      rnd = xorshift(rnd);
      mem_res.rdata = rd_word;
      mem_res.hold  = heavy ? (rnd[1:0] != 2'b00) : (rnd[2:0] == 3'b000);
   end

   // -------------------- Access for the testbench
   function automatic logic [7:0] shadow_byte(input logic [15:0] a);
      return shadow[a];
   endfunction

   function automatic void shadow_write(input logic [15:0] a, input logic [7:0] v);
      shadow[a] = v;
   endfunction

   function automatic int log_size();
      return wr_log.size();
   endfunction

   function automatic mem_req_t log_entry(input int i);
      return wr_log[i];
   endfunction

   function automatic void clear_log();
      wr_log.delete();
   endfunction

   // Words where the memory and the shadow disagree
   function automatic int mismatches();
      int n;
      n = 0;
      for (int i = 0; i < mem_words; i++)
         if (mem[i] != {shadow[4*i], shadow[4*i+1], shadow[4*i+2], shadow[4*i+3]})
            n++;
      return n;
   endfunction

endmodule

/* sim/tb_dcache.sv */
// --------------------
// Testbench for the data cache stage, requests replayed from restart_pc
// Addresses stay below 64 KiB so the memory model covers them
// --------------------
module tb_dcache
   import dcache_pkg::*;
();

   localparam int num_tests = 6;

   logic       clock;
   logic       rst;
   logic       heavy;
   stage_req_t req;
   stage_res_t res;
   logic       restart;
   logic [31:0] restart_pc;
   mem_req_t   mem_req;
   mem_res_t   mem_res;

   int         errors, checks, tests_run, err_at_start;
   int         next_commit, miss_restarts, full_restarts;
   int         restarts_at [32];
   stage_req_t prog [$];
   mem_req_t   exp_wr [$];

   dcache_stage uut (
      .clock, .rst, .req, .res, .restart, .restart_pc, .mem_req, .mem_res
   );

   tb_memory mem_model (
      .clock, .heavy, .mem_req, .mem_res
   );

   always #5 clock = ~clock;

   // A held bus request stays put until memory takes it
   assert property (@(posedge clock) disable iff (rst)
                    mem_res.hold && (mem_req.read || mem_req.write) |=> $stable(mem_req))
      else begin
         errors++;
         $display("Bus request changed while hold was high at %0t", $time);
      end

   // Watchdog
   initial begin
      #(num_tests * 2000);
      $display("Watchdog expired, the run did not finish in time");
      $display("Done: errors found");
      $finish;
   end

   // -------------------- Checks
   task automatic expect_true(input bit ok, input string what);
      checks++;
      assert (ok) else begin
         errors++;
         $display("[ERROR] %0t: %s", $time, what);
      end
   endtask

   task automatic expect_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
      checks++;
      assert (got === want) else begin
         errors++;
         $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, want);
      end
   endtask

   // -------------------- Reference model
   // Byte a is the most significant byte of a loaded half or word
   function automatic logic [31:0] load_value(input mem_op_e op, input logic [15:0] a);
      logic [7:0]  b;
      logic [15:0] h;
      logic [31:0] w;
      b = mem_model.shadow_byte(a);
      h = {mem_model.shadow_byte(a & 16'hfffe), mem_model.shadow_byte(a | 16'h0001)};
      w = {mem_model.shadow_byte(a & 16'hfffc), mem_model.shadow_byte((a & 16'hfffc) | 1),
           mem_model.shadow_byte((a & 16'hfffc) | 2), mem_model.shadow_byte(a | 16'h0003)};
      case (op)
         op_lb:   return {{24{b[7]}}, b};
         op_lbu:  return {24'b0, b};
         op_lh:   return {{16{h[15]}}, h};
         op_lhu:  return {16'b0, h};
         default: return w;
      endcase
   endfunction

   // Store goes to the shadow and queues the bus write it must cause
   task automatic record_store(input stage_req_t r);
      int          size;
      int          lane;
      logic [15:0] base;
      logic [15:0] ba;
      logic [7:0]  v;
      mem_req_t    w;
      size = (r.op == op_sw) ? 4 : (r.op == op_sh) ? 2 : 1;
      base = r.addr[15:0] & ~16'(size - 1);
      w = '0;
      w.write = 1'b1;
      w.addr = {r.addr[31:2], 2'b00};
      for (int n = 0; n < size; n++) begin
         ba = base + 16'(n);
         v = r.store_data[8*(size - 1 - n) +: 8];
         mem_model.shadow_write(ba, v);
         lane = 3 - int'(ba[1:0]);
         w.be[lane] = 1'b1;
         w.wdata[8*lane +: 8] = v;
      end
      exp_wr.push_back(w);
   endtask

   // -------------------- Stimulus
   task automatic add_req(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data);
      stage_req_t r;
      r = '0;
      r.valid = 1'b1;
      r.op = op;
      r.addr = addr;
      r.store_data = data;
      r.alu_res = 32'hc0de_0000 | 32'(prog.size() * 3);
      r.wbr = 6'(prog.size() + 1);
      r.pc = 32'(prog.size() * 4);
      prog.push_back(r);
   endtask

   // Result of one request slot, seen two edges after its tags were read
   task automatic check_slot(input int e);
      stage_req_t r;
      logic [31:0] want;
      r = prog[e];
      if (e != next_commit) begin
         expect_true(!res.valid, "squashed request produced a result");
         return;
      end
      if (res.valid) begin
         if (r.op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw})
            want = load_value(r.op, r.addr[15:0]);
         else
            want = r.alu_res;
         if (r.op inside {op_sb, op_sh, op_sw})
            record_store(r);
         expect_value(res.res, want, $sformatf("result of request %0d", e));
         expect_value(32'(res.wbr), 32'(r.wbr), $sformatf("wbr of request %0d", e));
         next_commit++;
      end else begin
         expect_true(restart && restart_pc == r.pc && r.op != op_none,
                     $sformatf("request %0d gave neither a result nor a restart", e));
         if (r.op inside {op_sb, op_sh, op_sw})
            full_restarts++;
         else
            miss_restarts++;
         restarts_at[e]++;
      end
   endtask

   // Issue back to back, resend from restart_pc once restart falls
   task automatic run_program();
      int ptr;
      int e;
      int pipe [3];
      ptr = 0;
      next_commit = 0;
      pipe = '{-1, -1, -1};
      while (next_commit < prog.size()) begin
         @(negedge clock);
         e = pipe[2];
         pipe[2] = pipe[1];
         pipe[1] = pipe[0];
         if (e >= 0)
            check_slot(e);
         if (restart) begin
            expect_value(restart_pc, prog[next_commit].pc, "restart_pc");
            ptr = next_commit;
            req = '0;
            pipe[0] = -1;
         end else if (ptr < prog.size()) begin
            req = prog[ptr];
            pipe[0] = ptr;
            ptr++;
         end else begin
            req = '0;
            pipe[0] = -1;
         end
      end
      req = '0;
   endtask

   task automatic start_test();
      prog.delete();
      exp_wr.delete();
      mem_model.clear_log();
      miss_restarts = 0;
      full_restarts = 0;
      for (int i = 0; i < 32; i++)
         restarts_at[i] = 0;
      err_at_start = errors;
   endtask

   // Drain the store buffer, then compare bus writes and memory
   task automatic end_test(input string name);
      int       n;
      mem_req_t got;
      mem_req_t want;
      logic [31:0] mask;
      n = 0;
      while (mem_model.log_size() < exp_wr.size() && n < 400) begin
         @(negedge clock);
         n++;
      end
      repeat (4) @(negedge clock);
      expect_value(mem_model.log_size(), exp_wr.size(), "bus write count");
      for (int i = 0; i < exp_wr.size() && i < mem_model.log_size(); i++) begin
         got = mem_model.log_entry(i);
         want = exp_wr[i];
         mask = {{8{want.be[3]}}, {8{want.be[2]}}, {8{want.be[1]}}, {8{want.be[0]}}};
         expect_value(got.addr, want.addr, $sformatf("address of bus write %0d", i));
         expect_value(32'(got.be), 32'(want.be), $sformatf("byte enables of bus write %0d", i));
         expect_value(got.wdata & mask, want.wdata & mask, $sformatf("data of bus write %0d", i));
      end
      expect_value(mem_model.mismatches(), 0, "memory words differing from shadow");
      tests_run++;
      if (errors == err_at_start)
         $display("test %0d %s: ok", tests_run, name);
      else
         $display("test %0d %s: %0d errors", tests_run, name, errors - err_at_start);
   endtask

   // -------------------- Tests
   initial begin
      clock = 1'b0;
      rst = 1'b1;
      heavy <= 1'b0;
      req = '0;
      errors = 0;
      checks = 0;
      tests_run = 0;
      repeat (2) @(negedge clock);
      rst = 1'b0;

      start_test();
      repeat (4) begin
         @(negedge clock);
         expect_true(!res.valid && !restart && !mem_req.read && !mem_req.write,
                     "outputs active after reset before any request");
      end
      end_test("reset state");

      // Cold line, then every load width from it
      start_test();
      add_req(op_lw, 32'h0100, 0);
      add_req(op_lb, 32'h0101, 0);
      add_req(op_lbu, 32'h0102, 0);
      add_req(op_lh, 32'h0106, 0);
      add_req(op_lhu, 32'h0108, 0);
      add_req(op_lw, 32'h010c, 0);
      add_req(op_lb, 32'h0103, 0);
      run_program();
      expect_value(miss_restarts, 1, "miss restarts");
      expect_value(restarts_at[0], 1, "restarts of the first load");
      end_test("cold load miss");

      start_test();
      add_req(op_sb, 32'h0101, 32'h0000_00e7);
      add_req(op_sh, 32'h0106, 32'h0000_9c35);
      add_req(op_sw, 32'h0108, 32'h1234_8765);
      add_req(op_lw, 32'h0100, 0);
      add_req(op_lw, 32'h0104, 0);
      add_req(op_lw, 32'h0108, 0);
      add_req(op_lb, 32'h0101, 0);
      add_req(op_lhu, 32'h0106, 0);
      run_program();
      expect_value(miss_restarts + full_restarts, 0, "restarts on cached stores");
      end_test("store hits");

      // Stores outrun the bus while hold is mostly high
      start_test();
      heavy <= 1'b1;
      for (int i = 0; i < 12; i++) begin
         case (i % 3)
            0: add_req(op_sw, 32'h2000 + 4*(i % 5), 32'ha500_0000 + i * 32'h0103_0507);
            1: add_req(op_sh, 32'h2000 + 4*(i % 5) + 2*(i % 2), 32'h0000_8e11 + i);
            default: add_req(op_sb, 32'h2000 + 4*(i % 5) + (i % 4), 32'h0000_00f0 + i);
         endcase
      end
      run_program();
      expect_true(full_restarts > 0, "store buffer never restarted a store");
      end_test("store burst");
      heavy <= 1'b0;

      // Five tags on index 3 push the first one out
      start_test();
      for (int k = 1; k <= 5; k++)
         add_req(op_lw, 32'h0030 + k * 32'h0100, 0);
      add_req(op_lw, 32'h0130, 0);
      add_req(op_lw, 32'h0530, 0);
      run_program();
      expect_value(miss_restarts, 6, "miss restarts");
      expect_value(restarts_at[5], 1, "restarts of the evicted line");
      expect_value(restarts_at[6], 0, "restarts of the newest line");
      end_test("round-robin eviction");

      start_test();
      add_req(op_none, 0, 0);
      add_req(op_lw, 32'h0104, 0);
      add_req(op_none, 0, 0);
      add_req(op_lbu, 32'h010d, 0);
      add_req(op_none, 0, 0);
      add_req(op_lh, 32'h0102, 0);
      add_req(op_none, 0, 0);
      run_program();
      expect_value(miss_restarts + full_restarts, 0, "restarts among hits");
      end_test("pass-through order");

      $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* all.f */
hw/dcache_pkg.sv
hw/tag_lookup.sv
hw/data_array.sv
hw/lane_format.sv
hw/store_buffer.sv
hw/line_fill.sv
hw/mem_arbiter.sv
hw/dcache_stage.sv
sim/tb_memory.sv
sim/tb_dcache.sv

/* run.sh */
#!/usr/bin/env bash
# Build the data cache testbench with Verilator, run it, and look for the pass line in the log
verilator --binary --timing -Wno-fatal --top-module tb_dcache -f all.f -o tb_dcache_sim \
   && ./obj_dir/tb_dcache_sim | tee sim.log \
   && grep -qx "Done: no errors" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
